// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal -f tb.f --top-module txtlcd_tb -Mdir obj_dir
	out="$$(./obj_dir/Vtxtlcd_tb)"; echo "$$out"; echo "$$out" | grep -qx "Testbench passed"

clean:
	rm -rf obj_dir

// File: hdl/disp_buffer_axil.sv
// ----------------------------------------
// display buffer with axi4-lite slave
// character ram, refresh request flag
// and sequencer status register
// ----------------------------------------

`include "txtlcd_defines.svh"

module disp_buffer_axil (
	input logic in_clk,
	input logic in_rst,
	input txtlcd_pkg::axil_req_t axil_req,
	output txtlcd_pkg::axil_rsp_t axil_rsp,
	input logic [`TXTLCD_ADDR_BITS-1:0] mem_addr,
	output logic [7:0] mem_word,
	output logic update_req,
	input logic update_ack,
	input txtlcd_pkg::lcd_status_t status
);

	localparam int aw = `TXTLCD_AXI_ADDR_BITS;
	localparam logic [aw-1:0] reg_ctrl = `TXTLCD_REG_CTRL;
	localparam logic [aw-1:0] reg_status = `TXTLCD_REG_STATUS;
	localparam logic [aw-1:0] char_end = aw'(`TXTLCD_SIZE * 4);
	localparam logic [1:0] resp_okay = 2'b00;
	localparam logic [1:0] resp_slverr = 2'b10;

	// one byte per 32 bit word
	logic [7:0] char_mem [`TXTLCD_SIZE];

	logic wr_go, rd_go;
	logic wr_is_char, wr_is_ctrl;
	logic rd_is_char, rd_is_ctrl, rd_is_status;
	logic [31:0] rd_word;
	logic rd_err;

	logic bvalid, rvalid;
	logic [1:0] bresp, rresp;
	logic [31:0] rdata;
	logic update_pending;

	// address and data taken together, none while a response waits
	assign wr_go = axil_req.awvalid && axil_req.wvalid && !bvalid;
	assign rd_go = axil_req.arvalid && !rvalid;

	// address decode, word aligned
	assign wr_is_char = axil_req.awaddr < char_end;
	assign wr_is_ctrl = axil_req.awaddr[aw-1:2] == reg_ctrl[aw-1:2];
	assign rd_is_char = axil_req.araddr < char_end;
	assign rd_is_ctrl = axil_req.araddr[aw-1:2] == reg_ctrl[aw-1:2];
	assign rd_is_status = axil_req.araddr[aw-1:2] == reg_status[aw-1:2];

	// read mux
	always_comb begin
		rd_word = '0;
		rd_err = 1'b0;
		if (rd_is_char)
			rd_word = {24'h0, char_mem[axil_req.araddr[`TXTLCD_ADDR_BITS+1:2]]};
		else if (rd_is_ctrl)
			rd_word = {31'h0, update_pending};
		else if (rd_is_status)
			rd_word = {16'h0, status.busy_flag, 5'h0, update_pending,
				status.updating, status.init_done};
		else
			rd_err = 1'b1;
	end

	// ----------------------------------------
	// handshake and refresh flag
	// ----------------------------------------
	always_ff @(posedge in_clk) begin
		if (in_rst) begin
			bvalid <= 1'b0;
			rvalid <= 1'b0;
			update_pending <= 1'b0;
		end else begin
			if (wr_go)
				bvalid <= 1'b1;
			else if (axil_req.bready)
				bvalid <= 1'b0;

			if (rd_go)
				rvalid <= 1'b1;
			else if (axil_req.rready)
				rvalid <= 1'b0;

			// host write beats the ack in the same cycle
			if (wr_go && wr_is_ctrl && axil_req.wstrb[0] && axil_req.wdata[0])
				update_pending <= 1'b1;
			else if (update_ack)
				update_pending <= 1'b0;
		end
	end

	// ----------------------------------------
	// ram and response payload
	// ----------------------------------------
	always_ff @(posedge in_clk) begin
		if (wr_go) begin
			bresp <= (wr_is_char || wr_is_ctrl) ? resp_okay : resp_slverr;
			if (wr_is_char && axil_req.wstrb[0])
				char_mem[axil_req.awaddr[`TXTLCD_ADDR_BITS+1:2]] <= axil_req.wdata[7:0];
		end
		if (rd_go) begin
			rdata <= rd_word;
			rresp <= rd_err ? resp_slverr : resp_okay;
		end
	end

	// sequencer port, asynchronous read
	assign mem_word = char_mem[mem_addr];
	assign update_req = update_pending;

	assign axil_rsp = '{
		awready: wr_go,
		wready: wr_go,
		bresp: bresp,
		bvalid: bvalid,
		arready: rd_go,
		rdata: rdata,
		rresp: rresp,
		rvalid: rvalid
	};

endmodule

// File: hdl/serial_bus_master.sv
// ----------------------------------------
// serial 3-wire bus master
// shifts bytes out lsb first on sclk/sdo,
// samples sdi for read bytes, one byte of
// buffering keeps frames back to back
// ----------------------------------------

`include "txtlcd_defines.svh"

module serial_bus_master (
	input logic in_clk,
	input logic in_rst,
	input txtlcd_pkg::bus_req_t req,
	output txtlcd_pkg::bus_rsp_t rsp,
	output logic sclk,
	output logic cs_n,
	output logic sdo,
	input logic sdi
);

	localparam int div_bits = $clog2(`TXTLCD_SCLK_DIV) + 1;

	// clock divider and bit position
	logic [div_bits-1:0] div_cnt;
	logic div_tick;
	logic [2:0] bit_cnt;
	logic shift_active;

	// shifter contents
	logic [6:0] tx_shift;
	logic [7:0] rx_shift;
	logic cur_read;

	// holding stage
	logic hold_valid;
	logic [7:0] hold_data;
	logic hold_read;

	logic ready;
	logic accept;
	logic byte_end;
	logic load;

	// take a new byte whenever the holding stage is free
	assign accept = req.enable && !hold_valid;
	assign div_tick = div_cnt == div_bits'(`TXTLCD_SCLK_DIV - 1);
	// end of the high phase of bit 7
	assign byte_end = shift_active && div_tick && sclk && (bit_cnt == 3'd7);
	// start a byte from idle or chain it onto the one just finished
	assign load = hold_valid && (!shift_active || byte_end);

	// ----------------------------------------
	// control
	// ----------------------------------------
	always_ff @(posedge in_clk) begin
		if (in_rst) begin
			hold_valid <= 1'b0;
			shift_active <= 1'b0;
			div_cnt <= '0;
			bit_cnt <= '0;
			sclk <= 1'b1;
			cs_n <= 1'b1;
			sdo <= 1'b0;
			ready <= 1'b1;
		end else begin
			if (accept) begin
				hold_valid <= 1'b1;
				ready <= 1'b0;
			end else if (load) begin
				hold_valid <= 1'b0;
			end

			if (load) begin
				// falling edge puts out bit 0
				shift_active <= 1'b1;
				cs_n <= 1'b0;
				sclk <= 1'b0;
				sdo <= hold_data[0];
				div_cnt <= '0;
				bit_cnt <= '0;
			end else if (shift_active) begin
				if (!div_tick) begin
					div_cnt <= div_cnt + 1'b1;
				end else begin
					div_cnt <= '0;
					if (!sclk) begin
						// rising edge, lcd samples sdo here
						sclk <= 1'b1;
					end else if (bit_cnt == 3'd7) begin
						// last bit done and nothing queued
						shift_active <= 1'b0;
						if (!req.enable) begin
							cs_n <= 1'b1;
							ready <= 1'b1;
						end
					end else begin
						sclk <= 1'b0;
						sdo <= tx_shift[0];
						bit_cnt <= bit_cnt + 1'b1;
					end
				end
			end
		end
	end

	// ----------------------------------------
	// data path
	// ----------------------------------------
	always_ff @(posedge in_clk) begin
		if (accept) begin
			hold_data <= req.data;
			hold_read <= req.read;
		end

		if (load) begin
			tx_shift <= hold_data[7:1];
			cur_read <= hold_read;
		end else if (shift_active && div_tick) begin
			if (!sclk) begin
				// sample on the rising edge, lsb arrives first
				if (cur_read)
					rx_shift <= {sdi, rx_shift[7:1]};
			end else if (bit_cnt != 3'd7) begin
				tx_shift <= {1'b0, tx_shift[6:1]};
			end
		end
	end

	// rx_shift only moves in read bytes, so it keeps the last one read
	assign rsp = '{ready: ready, next: accept, rx_data: rx_shift};

endmodule

// File: hdl/txtlcd_ctrl.sv
// ----------------------------------------
// text lcd sequencer
// resets the display, sends the fixed
// init sequence with busy polling or a
// timer, then refreshes all characters
// on request
// ----------------------------------------

`include "txtlcd_defines.svh"

module txtlcd_ctrl #(
	parameter bit READ_BUSY_FLAG = 1'b1
) (
	input logic in_clk,
	input logic in_rst,
	output txtlcd_pkg::bus_req_t bus_req,
	input txtlcd_pkg::bus_rsp_t bus_rsp,
	output logic [`TXTLCD_ADDR_BITS-1:0] mem_addr,
	input logic [7:0] mem_word,
	input logic update_req,
	output logic update_ack,
	output txtlcd_pkg::lcd_status_t status,
	output logic lcd_rst_n
);

	import txtlcd_pkg::*;

	localparam int init_len = 22;
	localparam int wait_bits = $clog2(`TXTLCD_WAIT_PRERESET + `TXTLCD_WAIT_RESET +
		`TXTLCD_WAIT_RESETTED + `TXTLCD_WAIT_INIT + `TXTLCD_WAIT_UPDATE);
	localparam int write_bits = $clog2(`TXTLCD_SIZE + 1);

	// ----------------------------------------
	// init sequence, opcode and instruction
	// ----------------------------------------
	localparam logic [11:0] init_tab [init_len] = '{
		// 8 bit, 4 lines, re=1 is=1
		{ctrl_command, 8'h3b},
		// leave power down
		{ctrl_command, 8'h02},
		// entry mode, bottom view
		{ctrl_command, 8'h06},
		// 4 line display
		{ctrl_command, 8'h09},
		// no line shift
		{ctrl_command, 8'h10},
		// scroll quantity 0
		{ctrl_command, 8'hc0},
		// rom select, then rom a
		{ctrl_command, 8'h72},
		{ctrl_data, 8'h00},
		// temperature coefficient
		{ctrl_command, 8'h76},
		{ctrl_data, 8'h02},
		// re=1 is=0
		{ctrl_command, 8'h3a},
		// bias bit bs1
		{ctrl_command, 8'h12},
		// re=0 is=1
		{ctrl_command, 8'h39},
		// bias bs0 and oscillator
		{ctrl_command, 8'h1b},
		// booster on, contrast high bits
		{ctrl_command, 8'h57},
		// contrast low bits
		{ctrl_command, 8'h70},
		// follower on, ratio 6
		{ctrl_command, 8'h6e},
		// re=0 is=0
		{ctrl_command, 8'h38},
		// cursor moves right
		{ctrl_command, 8'h06},
		// display on, no cursor, no blink
		{ctrl_command, 8'h0c},
		// clear, then return home
		{ctrl_command, 8'h01},
		{ctrl_command, 8'h02}
	};

	// start byte, five ones then rw and rs when sent lsb first
	function automatic logic [7:0] ctrl_byte(input ctrl_kind_t kind);
		return {kind, 4'hf};
	endfunction

	lcd_state_t state, state_nxt;
	// where to go once the busy flag clears
	lcd_state_t ret_state, ret_state_nxt;

	logic [wait_bits-1:0] wait_cnt;
	logic [$clog2(init_len+1)-1:0] init_cycle, init_cycle_nxt;
	logic [1:0] byte_idx, byte_idx_nxt;
	logic [write_bits-1:0] write_cycle, write_cycle_nxt;
	logic [11:0] init_entry;

	logic init_done, init_done_nxt;
	logic updating, updating_nxt;
	logic [7:0] busy_flag, busy_flag_nxt;

	assign init_entry = init_tab[init_cycle];

	// ----------------------------------------
	// state registers
	// ----------------------------------------
	always_ff @(posedge in_clk) begin
		if (in_rst) begin
			state <= st_wait_reset;
			ret_state <= st_wait_reset;
			wait_cnt <= '0;
			init_cycle <= '0;
			byte_idx <= '0;
			write_cycle <= '0;
			init_done <= 1'b0;
			updating <= 1'b0;
			busy_flag <= 8'hff;
		end else begin
			state <= state_nxt;
			ret_state <= ret_state_nxt;
			// one shared timer, restarts on every state change
			if (state_nxt != state)
				wait_cnt <= '0;
			else
				wait_cnt <= wait_cnt + 1'b1;
			init_cycle <= init_cycle_nxt;
			byte_idx <= byte_idx_nxt;
			write_cycle <= write_cycle_nxt;
			init_done <= init_done_nxt;
			updating <= updating_nxt;
			busy_flag <= busy_flag_nxt;
		end
	end

	// ----------------------------------------
	// next state and bus requests
	// ----------------------------------------
	always_comb begin
		state_nxt = state;
		ret_state_nxt = ret_state;
		init_cycle_nxt = init_cycle;
		byte_idx_nxt = byte_idx;
		write_cycle_nxt = write_cycle;
		init_done_nxt = init_done;
		updating_nxt = updating;
		busy_flag_nxt = busy_flag;
		bus_req = '0;
		update_ack = 1'b0;

		unique case (state)
			// display reset pulse
			st_wait_reset: begin
				if (wait_cnt == wait_bits'(`TXTLCD_WAIT_PRERESET - 1))
					state_nxt = st_reset;
			end
			st_reset: begin
				busy_flag_nxt = 8'hff;
				if (wait_cnt == wait_bits'(`TXTLCD_WAIT_RESET - 1))
					state_nxt = st_resetted;
			end
			st_resetted: begin
				if (wait_cnt == wait_bits'(`TXTLCD_WAIT_RESETTED - 1))
					state_nxt = st_init_seq;
			end

			// start byte, low nibble, high nibble per instruction
			st_init_seq: begin
				if (init_cycle == init_len) begin
					// all sent, wait for the last byte to leave
					if (bus_rsp.ready) begin
						init_done_nxt = 1'b1;
						state_nxt = st_wait_update;
					end
				end else begin
					bus_req.enable = 1'b1;
					case (byte_idx)
						2'd0: bus_req.data = ctrl_byte(ctrl_kind_t'(init_entry[11:8]));
						2'd1: bus_req.data = {4'h0, init_entry[3:0]};
						default: bus_req.data = {4'h0, init_entry[7:4]};
					endcase
					if (bus_rsp.next) begin
						if (byte_idx == 2'd2) begin
							byte_idx_nxt = '0;
							init_cycle_nxt = init_cycle + 1'b1;
							state_nxt = st_wait_init;
						end else begin
							byte_idx_nxt = byte_idx + 1'b1;
						end
					end
				end
			end
			st_wait_init: begin
				if (READ_BUSY_FLAG) begin
					state_nxt = st_busy_cmd;
					ret_state_nxt = st_init_seq;
				end else if (wait_cnt == wait_bits'(`TXTLCD_WAIT_INIT - 1)) begin
					state_nxt = st_init_seq;
				end
			end

			// busy flag poll, start byte then one read byte
			st_busy_cmd: begin
				bus_req.enable = 1'b1;
				bus_req.data = ctrl_byte(ctrl_read);
				if (bus_rsp.next)
					state_nxt = st_busy_read;
			end
			st_busy_read: begin
				bus_req.enable = 1'b1;
				bus_req.read = 1'b1;
				if (bus_rsp.next)
					state_nxt = st_busy_wait;
			end
			st_busy_wait: begin
				if (bus_rsp.ready) begin
					busy_flag_nxt = bus_rsp.rx_data;
					state_nxt = st_busy_check;
				end
			end
			st_busy_check: begin
				// bit 7 set, poll again in a fresh frame
				state_nxt = busy_flag[7] ? st_busy_cmd : ret_state;
			end

			// refresh
			st_wait_update: begin
				if (wait_cnt == wait_bits'(`TXTLCD_WAIT_UPDATE - 1))
					state_nxt = st_pre_update;
			end
			st_pre_update: begin
				if (update_req) begin
					update_ack = 1'b1;
					updating_nxt = 1'b1;
					if (READ_BUSY_FLAG) begin
						state_nxt = st_busy_cmd;
						ret_state_nxt = st_home_ctrl;
					end else begin
						state_nxt = st_home_ctrl;
					end
				end
			end
			// return home, instruction 0x02
			st_home_ctrl: begin
				bus_req.enable = 1'b1;
				bus_req.data = ctrl_byte(ctrl_command);
				if (bus_rsp.next)
					state_nxt = st_home_lo;
			end
			st_home_lo: begin
				bus_req.enable = 1'b1;
				bus_req.data = 8'h02;
				if (bus_rsp.next)
					state_nxt = st_home_hi;
			end
			st_home_hi: begin
				bus_req.enable = 1'b1;
				bus_req.data = 8'h00;
				if (bus_rsp.next)
					state_nxt = st_home_wait;
			end
			st_home_wait: begin
				if (READ_BUSY_FLAG) begin
					state_nxt = st_busy_cmd;
					ret_state_nxt = st_data_ctrl;
				end else if (wait_cnt == wait_bits'(`TXTLCD_WAIT_INIT - 1)) begin
					state_nxt = st_data_ctrl;
				end
			end
			st_data_ctrl: begin
				bus_req.enable = 1'b1;
				bus_req.data = ctrl_byte(ctrl_data);
				if (bus_rsp.next) begin
					write_cycle_nxt = '0;
					byte_idx_nxt = '0;
					state_nxt = st_update;
				end
			end
			// two nibble bytes per character, one data frame
			st_update: begin
				if (write_cycle == write_bits'(`TXTLCD_SIZE)) begin
					if (bus_rsp.ready) begin
						updating_nxt = 1'b0;
						state_nxt = st_wait_update;
					end
				end else begin
					bus_req.enable = 1'b1;
					bus_req.data = byte_idx[0] ? {4'h0, mem_word[7:4]} : {4'h0, mem_word[3:0]};
					if (bus_rsp.next) begin
						byte_idx_nxt = {1'b0, ~byte_idx[0]};
						if (byte_idx[0])
							write_cycle_nxt = write_cycle + 1'b1;
					end
				end
			end
			default: state_nxt = st_wait_reset;
		endcase
	end

	assign mem_addr = `TXTLCD_ADDR_BITS'(write_cycle);
	assign lcd_rst_n = state != st_reset;
	assign status = '{init_done: init_done, updating: updating, busy_flag: busy_flag};

endmodule

// File: hdl/txtlcd_pkg.sv
// ----------------------------------------
// text lcd subsystem types
// serial bus handshake, axi4-lite channel
// bundles, sequencer states and opcodes
// ----------------------------------------

`include "txtlcd_defines.svh"

package txtlcd_pkg;

	// ----------------------------------------
	// sequencer to serial bus master
	// ----------------------------------------
	typedef struct packed {
		logic enable;
		logic [7:0] data;
		// capture sdi during this byte
		logic read;
	} bus_req_t;

	typedef struct packed {
		// shifter and holding stage empty
		logic ready;
		// byte taken, next one may follow
		logic next;
		logic [7:0] rx_data;
	} bus_rsp_t;

	// ----------------------------------------
	// axi4-lite channels
	// ----------------------------------------
	typedef struct packed {
		logic [`TXTLCD_AXI_ADDR_BITS-1:0] awaddr;
		logic awvalid;
		logic [31:0] wdata;
		logic [3:0] wstrb;
		logic wvalid;
		logic bready;
		logic [`TXTLCD_AXI_ADDR_BITS-1:0] araddr;
		logic arvalid;
		logic rready;
	} axil_req_t;

	typedef struct packed {
		logic awready;
		logic wready;
		logic [1:0] bresp;
		logic bvalid;
		logic arready;
		logic [31:0] rdata;
		logic [1:0] rresp;
		logic rvalid;
	} axil_rsp_t;

	// sequencer state seen by the register block
	typedef struct packed {
		logic init_done;
		logic updating;
		logic [7:0] busy_flag;
	} lcd_status_t;

	// ----------------------------------------
	// sequencer
	// ----------------------------------------
	typedef enum logic [4:0] {
		st_wait_reset, st_reset, st_resetted,
		st_init_seq, st_wait_init,
		st_busy_cmd, st_busy_read, st_busy_wait, st_busy_check,
		st_wait_update, st_pre_update,
		st_home_ctrl, st_home_lo, st_home_hi, st_home_wait,
		st_data_ctrl, st_update
	} lcd_state_t;

	// high nibble of the start byte, rs and rw encoded
	typedef enum logic [3:0] {
		ctrl_command = 4'b0001,
		ctrl_data = 4'b0101,
		ctrl_read = 4'b0011
	} ctrl_kind_t;

endpackage

// File: hdl/txtlcd_top.sv
// ----------------------------------------
// text lcd subsystem top
// host buffer, sequencer and serial bus
// master wired to the lcd pins
// ----------------------------------------

`include "txtlcd_defines.svh"

module txtlcd_top (
	input logic in_clk,
	input logic in_rst,
	input txtlcd_pkg::axil_req_t axil_req,
	output txtlcd_pkg::axil_rsp_t axil_rsp,
	output logic lcd_rst_n,
	output logic lcd_sclk,
	output logic lcd_cs_n,
	output logic lcd_sdo,
	input logic lcd_sdi
);

	import txtlcd_pkg::*;

	// sequencer to bus master
	bus_req_t bus_req;
	bus_rsp_t bus_rsp;

	// buffer read port and refresh handoff
	logic [`TXTLCD_ADDR_BITS-1:0] mem_addr;
	logic [7:0] mem_word;
	logic update_req;
	logic update_ack;
	lcd_status_t status;

	disp_buffer_axil u_buffer (
		.in_clk(in_clk),
		.in_rst(in_rst),
		.axil_req(axil_req),
		.axil_rsp(axil_rsp),
		.mem_addr(mem_addr),
		.mem_word(mem_word),
		.update_req(update_req),
		.update_ack(update_ack),
		.status(status)
	);

	// busy flag polling between instructions
	txtlcd_ctrl #(
		.READ_BUSY_FLAG(1'b1)
	) u_ctrl (
		.in_clk(in_clk),
		.in_rst(in_rst),
		.bus_req(bus_req),
		.bus_rsp(bus_rsp),
		.mem_addr(mem_addr),
		.mem_word(mem_word),
		.update_req(update_req),
		.update_ack(update_ack),
		.status(status),
		.lcd_rst_n(lcd_rst_n)
	);

	serial_bus_master u_bus (
		.in_clk(in_clk),
		.in_rst(in_rst),
		.req(bus_req),
		.rsp(bus_rsp),
		.sclk(lcd_sclk),
		.cs_n(lcd_cs_n),
		.sdo(lcd_sdo),
		.sdi(lcd_sdi)
	);

endmodule

// File: include/txtlcd_defines.svh
// ----------------------------------------
// text lcd subsystem constants
// display size, serial clock divider,
// sequencer delays in clock cycles and
// register offsets of the host port
// ----------------------------------------

`ifndef TXTLCD_DEFINES_SVH
`define TXTLCD_DEFINES_SVH

// 4 lines of 20 characters
`define TXTLCD_SIZE 80
`define TXTLCD_ADDR_BITS 7

// system clocks per half sclk period
`define TXTLCD_SCLK_DIV 4

// sequencer delays in clock cycles
// short values for simulation, raise these for a hardware build
`define TXTLCD_WAIT_PRERESET 200
`define TXTLCD_WAIT_RESET 50
`define TXTLCD_WAIT_RESETTED 100
`define TXTLCD_WAIT_INIT 40
`define TXTLCD_WAIT_UPDATE 100

// axi4-lite register map
// characters sit at 0x000 to 0x13c, the registers above them
`define TXTLCD_AXI_ADDR_BITS 12
`define TXTLCD_REG_CTRL 12'h200
`define TXTLCD_REG_STATUS 12'h204

`endif

// File: tb.f
+incdir+include
hdl/txtlcd_pkg.sv
hdl/serial_bus_master.sv
hdl/txtlcd_ctrl.sv
hdl/disp_buffer_axil.sv
hdl/txtlcd_top.sv
verification/lcd_model.sv
verification/txtlcd_tb.sv

// File: verification/lcd_model.sv
// ----------------------------------------
// behavioral text lcd on the 3-wire bus
// decodes frames into instructions, keeps
// a character ram and an instruction log,
// answers busy flag reads
// ----------------------------------------

`include "txtlcd_defines.svh"

module lcd_model (
	input logic sclk,
	input logic cs_n,
	input logic sdo,
	output logic sdi
);

	localparam int log_max = 256;

	// start byte high nibble {0, rs, rw, 1}
	localparam logic [3:0] kind_data = 4'b0101;
	localparam logic [3:0] kind_read = 4'b0011;

	// display contents and instruction log
	logic [7:0] char_ram [`TXTLCD_SIZE];
	logic [3:0] log_kind [log_max];
	logic [7:0] log_byte [log_max];
	int log_count;
	logic protocol_error;

	// frame decoding
	logic [7:0] rx_byte;
	int bit_cnt;
	logic [3:0] kind;
	logic have_start;
	logic nib_half;
	logic [3:0] nib_lo;
	logic read_byte;

	// busy flag answer
	logic [6:0] addr;
	int busy_polls;
	logic [7:0] answer;
	int tx_bit;
	logic [31:0] rand_state;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// one complete command or data instruction
	task automatic take_instruction(input logic [7:0] code);
		// host should have polled while still busy
		if (busy_polls != 0)
			protocol_error = 1'b1;
		if (log_count < log_max) begin
			log_kind[log_count] = kind;
			log_byte[log_count] = code;
		end
		log_count++;
		if (kind == kind_data) begin
			if (addr < 7'(`TXTLCD_SIZE))
				char_ram[addr] = code;
			addr = addr + 1'b1;
		end else begin
			// clear display
			if (code == 8'h01) begin
				for (int i = 0; i < `TXTLCD_SIZE; i++)
					char_ram[i] = 8'h20;
				addr = '0;
			end else if (code[7:1] == 7'h01) begin
				// return home
				addr = '0;
			end
			// busy for 0 to 3 polls
			rand_state = xorshift32(rand_state);
			busy_polls = int'(rand_state[1:0]);
		end
	endtask

	task automatic take_byte(input logic [7:0] b);
		if (read_byte) begin
			// end of the dummy read byte
			read_byte = 1'b0;
			if (busy_polls != 0)
				busy_polls--;
		end else if (b[3:0] == 4'hf && b[7:4] != 4'h0) begin
			// start byte with rs and rw in the high nibble
			kind = b[7:4];
			have_start = 1'b1;
			nib_half = 1'b0;
			if (kind == kind_read) begin
				read_byte = 1'b1;
				answer = {busy_polls != 0, addr};
			end
		end else if (have_start) begin
			// low nibble first, then high nibble
			if (!nib_half) begin
				nib_lo = b[3:0];
				nib_half = 1'b1;
			end else begin
				nib_half = 1'b0;
				take_instruction({b[3:0], nib_lo});
			end
		end
	endtask

	initial begin
		for (int i = 0; i < `TXTLCD_SIZE; i++)
			char_ram[i] = 8'h20;
		log_count = 0;
		protocol_error = 1'b0;
		bit_cnt = 0;
		have_start = 1'b0;
		nib_half = 1'b0;
		read_byte = 1'b0;
		addr = '0;
		busy_polls = 0;
		answer = '0;
		tx_bit = 0;
		rand_state = 32'h25a7_1c24;
		sdi = 1'b0;
	end

	// sample sdo on rising sclk
	// frame ends with cs_n high
	always @(posedge sclk or posedge cs_n) begin
		if (cs_n !== 1'b0) begin
			bit_cnt = 0;
			have_start = 1'b0;
			nib_half = 1'b0;
			read_byte = 1'b0;
		end else begin
			rx_byte = {sdo, rx_byte[7:1]};
			bit_cnt++;
			if (bit_cnt == 8) begin
				bit_cnt = 0;
				take_byte(rx_byte);
			end
		end
	end

	// read answer goes out lsb first on falling sclk
	always @(negedge sclk) begin
		if (read_byte) begin
			sdi <= answer[tx_bit];
			tx_bit = tx_bit + 1;
		end else begin
			tx_bit = 0;
		end
	end

endmodule

// File: verification/txtlcd_tb.sv
// ----------------------------------------
// text lcd subsystem testbench
// reset pulse, init sequence, buffer
// access over axi4-lite, refresh and
// response back-pressure
// ----------------------------------------

`include "txtlcd_defines.svh"

module txtlcd_tb;

	import txtlcd_pkg::*;

	localparam int aw = `TXTLCD_AXI_ADDR_BITS;
	localparam int hs_limit = 100;
	localparam int poll_limit = 20000;
	localparam logic [1:0] resp_okay = 2'b00;
	localparam logic [1:0] resp_slverr = 2'b10;
	// start byte high nibble {0, rs, rw, 1}
	localparam logic [3:0] k_cmd = 4'b0001;
	localparam logic [3:0] k_dat = 4'b0101;

	// expected init instructions as kind and byte
	localparam logic [11:0] init_expect [22] = '{
		{k_cmd, 8'h3b}, {k_cmd, 8'h02}, {k_cmd, 8'h06}, {k_cmd, 8'h09},
		{k_cmd, 8'h10}, {k_cmd, 8'hc0}, {k_cmd, 8'h72}, {k_dat, 8'h00},
		{k_cmd, 8'h76}, {k_dat, 8'h02}, {k_cmd, 8'h3a}, {k_cmd, 8'h12},
		{k_cmd, 8'h39}, {k_cmd, 8'h1b}, {k_cmd, 8'h57}, {k_cmd, 8'h70},
		{k_cmd, 8'h6e}, {k_cmd, 8'h38}, {k_cmd, 8'h06}, {k_cmd, 8'h0c},
		{k_cmd, 8'h01}, {k_cmd, 8'h02}
	};

	// four lines of twenty characters
	string screen_text = {"SSD1803A text panel ", "line two  0123456789",
		"AXI4-Lite host write", "refresh over 3 wires"};

	logic in_clk;
	logic in_rst;
	axil_req_t axil_req;
	axil_rsp_t axil_rsp;
	logic lcd_rst_n;
	logic lcd_sclk;
	logic lcd_cs_n;
	logic lcd_sdo;
	logic lcd_sdi;

	logic [7:0] expect_chars [`TXTLCD_SIZE];
	logic [31:0] rnd;
	int check_count = 0;
	int err_count = 0;
	int timeout_count = 0;

	// reset pulse monitor
	int rst_low_cycles = 0;
	int rst_pulses = 0;
	int early_frames = 0;
	logic rst_prev = 1'b1;

	txtlcd_top dut (
		.in_clk(in_clk),
		.in_rst(in_rst),
		.axil_req(axil_req),
		.axil_rsp(axil_rsp),
		.lcd_rst_n(lcd_rst_n),
		.lcd_sclk(lcd_sclk),
		.lcd_cs_n(lcd_cs_n),
		.lcd_sdo(lcd_sdo),
		.lcd_sdi(lcd_sdi)
	);

	lcd_model lcd (
		.sclk(lcd_sclk),
		.cs_n(lcd_cs_n),
		.sdo(lcd_sdo),
		.sdi(lcd_sdi)
	);

	always #5 in_clk = ~in_clk;

	// count low cycles and completed pulses of lcd_rst_n
	always @(negedge in_clk) begin
		if (!in_rst) begin
			if (!lcd_rst_n)
				rst_low_cycles++;
			if (lcd_rst_n && !rst_prev)
				rst_pulses++;
			if (lcd_cs_n !== 1'b1 && rst_pulses == 0)
				early_frames++;
			rst_prev = lcd_rst_n;
		end
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] expected);
		check_count++;
		if (got !== expected) begin
			err_count++;
			$display("FAILED %s: got 0x%h, expected 0x%h", name, got, expected);
		end
	endtask

	task automatic note_timeout(input string what);
		timeout_count++;
		$display("timeout while waiting for %s", what);
	endtask

	// ----------------------------------------
	// axi4-lite master
	// ----------------------------------------
	task automatic axi_write(input logic [aw-1:0] addr, input logic [31:0] data,
			input int hold, output logic [1:0] resp);
		int n;
		@(posedge in_clk);
		axil_req.awaddr <= addr;
		axil_req.awvalid <= 1'b1;
		axil_req.wdata <= data;
		axil_req.wstrb <= 4'hf;
		axil_req.wvalid <= 1'b1;
		n = 0;
		@(negedge in_clk);
		while (!(axil_rsp.awready || axil_rsp.wready) && n < hs_limit) begin
			@(negedge in_clk);
			n++;
		end
		if (!(axil_rsp.awready || axil_rsp.wready)) begin
			note_timeout("awready and wready");
		end else begin
			// both channels are taken in the same cycle
			check("awready", 32'(axil_rsp.awready), 32'd1);
			check("wready", 32'(axil_rsp.wready), 32'd1);
		end
		@(posedge in_clk);
		axil_req.awvalid <= 1'b0;
		axil_req.wvalid <= 1'b0;
		n = 0;
		@(negedge in_clk);
		while (!axil_rsp.bvalid && n < hs_limit) begin
			@(negedge in_clk);
			n++;
		end
		if (!axil_rsp.bvalid)
			note_timeout("bvalid");
		resp = axil_rsp.bresp;
		// response must stay put while bready is low
		repeat (hold) begin
			@(negedge in_clk);
			check("bvalid", 32'(axil_rsp.bvalid), 32'd1);
			check("bresp", 32'(axil_rsp.bresp), 32'(resp));
		end
		@(posedge in_clk);
		axil_req.bready <= 1'b1;
		@(posedge in_clk);
		axil_req.bready <= 1'b0;
	endtask

	task automatic axi_read(input logic [aw-1:0] addr, input int hold,
			output logic [31:0] data, output logic [1:0] resp);
		int n;
		@(posedge in_clk);
		axil_req.araddr <= addr;
		axil_req.arvalid <= 1'b1;
		n = 0;
		@(negedge in_clk);
		while (!axil_rsp.arready && n < hs_limit) begin
			@(negedge in_clk);
			n++;
		end
		if (!axil_rsp.arready)
			note_timeout("arready");
		@(posedge in_clk);
		axil_req.arvalid <= 1'b0;
		n = 0;
		@(negedge in_clk);
		while (!axil_rsp.rvalid && n < hs_limit) begin
			@(negedge in_clk);
			n++;
		end
		if (!axil_rsp.rvalid)
			note_timeout("rvalid");
		data = axil_rsp.rdata;
		resp = axil_rsp.rresp;
		repeat (hold) begin
			@(negedge in_clk);
			check("rvalid", 32'(axil_rsp.rvalid), 32'd1);
			check("rdata", axil_rsp.rdata, data);
			check("rresp", 32'(axil_rsp.rresp), 32'(resp));
		end
		@(posedge in_clk);
		axil_req.rready <= 1'b1;
		@(posedge in_clk);
		axil_req.rready <= 1'b0;
	endtask

	// poll one status bit until it reaches the value
	task automatic wait_status(input int bit_idx, input logic value, input string what);
		logic [31:0] data;
		logic [1:0] resp;
		int n;
		n = 0;
		do begin
			axi_read(`TXTLCD_REG_STATUS, 0, data, resp);
			n++;
		end while (data[bit_idx] !== value && n < poll_limit);
		if (data[bit_idx] !== value)
			note_timeout(what);
	endtask

	// ctrl write, then a full pass of updating
	task automatic run_refresh();
		logic [1:0] resp;
		int base;
		base = lcd.log_count;
		axi_write(`TXTLCD_REG_CTRL, 32'h1, 0, resp);
		check("ctrl bresp", 32'(resp), 32'(resp_okay));
		wait_status(1, 1'b1, "updating high");
		wait_status(1, 1'b0, "updating low");
		// return-home first, then the 80 characters
		check("refresh log length", lcd.log_count - base, 32'd81);
		check("refresh first kind", 32'(lcd.log_kind[base]), 32'(k_cmd));
		check("refresh first byte", 32'(lcd.log_byte[base]), 32'h02);
		for (int i = 0; i < `TXTLCD_SIZE; i++)
			check($sformatf("lcd char %0d", i), 32'(lcd.char_ram[i]), 32'(expect_chars[i]));
	endtask

	initial begin
		logic [1:0] resp;
		logic [31:0] data;
		int pos;
		in_clk = 1'b0;
		in_rst = 1'b1;
		axil_req = '0;
		rnd = 32'h25a7_1c24;
		for (int i = 0; i < `TXTLCD_SIZE; i++)
			expect_chars[i] = screen_text[i];
		repeat (10) @(posedge in_clk);
		in_rst <= 1'b0;

		// ----------------------------------------
		// reset pulse and init sequence
		// ----------------------------------------
		wait_status(0, 1'b1, "init_done");
		check("lcd_rst_n pulses", rst_pulses, 32'd1);
		if (rst_low_cycles < `TXTLCD_WAIT_RESET - 1 || rst_low_cycles > `TXTLCD_WAIT_RESET + 1)
			check("lcd_rst_n low cycles", rst_low_cycles, `TXTLCD_WAIT_RESET);
		check("cs_n before reset pulse", early_frames, 32'd0);
		check("init log length", lcd.log_count, 32'd22);
		for (int i = 0; i < 22; i++) begin
			check($sformatf("init kind %0d", i), 32'(lcd.log_kind[i]), 32'(init_expect[i][11:8]));
			check($sformatf("init byte %0d", i), 32'(lcd.log_byte[i]), 32'(init_expect[i][7:0]));
		end

		// ----------------------------------------
		// buffer access
		// ----------------------------------------
		for (int i = 0; i < `TXTLCD_SIZE; i++) begin
			axi_write(aw'(i * 4), 32'(expect_chars[i]), 0, resp);
			check("char bresp", 32'(resp), 32'(resp_okay));
		end
		for (int i = 0; i < `TXTLCD_SIZE; i++) begin
			axi_read(aw'(i * 4), 0, data, resp);
			check($sformatf("char rdata %0d", i), data, 32'(expect_chars[i]));
			check("char rresp", 32'(resp), 32'(resp_okay));
		end
		// one past the last character, and a hole in the map
		axi_write(aw'(`TXTLCD_SIZE * 4), 32'h55, 0, resp);
		check("unmapped bresp", 32'(resp), 32'(resp_slverr));
		axi_read(aw'(12'h300), 0, data, resp);
		check("unmapped rresp", 32'(resp), 32'(resp_slverr));
		check("unmapped rdata", data, 32'h0);

		// first refresh
		run_refresh();

		// ----------------------------------------
		// back-pressure on b and r channels
		// ----------------------------------------
		for (int k = 0; k < 12; k++) begin
			rnd = xorshift32(rnd);
			pos = int'(rnd % 32'd80);
			data = 32'h40 + 32'(rnd[12:8]);
			expect_chars[pos] = data[7:0];
			axi_write(aw'(pos * 4), data, int'(rnd[18:16]), resp);
			check("modify bresp", 32'(resp), 32'(resp_okay));
		end
		for (int i = 0; i < `TXTLCD_SIZE; i++) begin
			rnd = xorshift32(rnd);
			axi_read(aw'(i * 4), int'(rnd[2:0]), data, resp);
			check($sformatf("modified rdata %0d", i), data, 32'(expect_chars[i]));
			check("modified rresp", 32'(resp), 32'(resp_okay));
		end

		// second refresh shows the changes
		run_refresh();
		check("lcd protocol error", 32'(lcd.protocol_error), 32'd0);

		$display("checks %0d, errors %0d, timeouts %0d", check_count, err_count, timeout_count);
		if (err_count == 0 && timeout_count == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule
